/* pg_consts.svh */
// Register map, frame layout limits and reset values, included by the RTL and testbench
`ifndef PG_CONSTS_SVH
`define PG_CONSTS_SVH

// ----------------------------------------------------------
// Register byte addresses, decoded on the low 8 bits
// ----------------------------------------------------------
`define PG_ADDR_START       8'h00 // Write 1 starts a run
`define PG_ADDR_STOP        8'h04
`define PG_ADDR_DONE        8'h08 // Read only
`define PG_ADDR_NUMPKTS     8'h0C // 0 runs until stopped
`define PG_ADDR_PKTLEN      8'h10
`define PG_ADDR_MACSA0      8'h14 // SA[31:0]
`define PG_ADDR_MACSA1      8'h18 // SA[47:32]
`define PG_ADDR_MACDA0      8'h1C // DA[31:0]
`define PG_ADDR_MACDA1      8'h20 // DA[47:32]
`define PG_ADDR_IDLE_CNT    8'h24
`define PG_ADDR_TXPKTCNT    8'h28
`define PG_ADDR_MON_CTRL    8'h50 // Bit 0 clears the monitor
`define PG_ADDR_GOOD_PKTS   8'h54
`define PG_ADDR_ERR_PKTS    8'h5C
`define PG_ADDR_RX_BYTES    8'h64
`define PG_ADDR_VLAN_EN     8'h70
`define PG_ADDR_VLAN_WORD   8'h78

// ----------------------------------------------------------
// Frame layout
// ----------------------------------------------------------
`define PG_ETH_HDR_BYTES    16'd14   // DA + SA + type/length
`define PG_MIN_PKT_LEN      11'd24
`define PG_MAX_PKT_LEN      11'd2047
`define PG_PKTLEN_W         11

// Register reset values
`define PG_RST_NUM_PKTS     32'd1
`define PG_RST_PKT_LEN      11'd64
`define PG_RST_IDLE_CNT     16'd12
`define PG_RST_VLAN_WORD    32'h8100_0000 // TPID 0x8100, VID 0

`endif

/* pg_regs_pkg.sv */
// Register-side types shared by the register file, the generator and the monitor
`include "pg_consts.svh"

package pg_regs_pkg;

	// One APB access as seen by the register file
	typedef struct packed {
		logic        sel;
		logic        enable;
		logic        write;
		logic [7:0]  addr;
		logic [31:0] wdata;
	} apb_req_t;

	// ----------------------------------------------------------
	// Generator configuration, driven from the register file
	// ----------------------------------------------------------
	typedef struct packed {
		logic [31:0]              num_pkts;  // 0 means run until stop
		logic [`PG_PKTLEN_W-1:0] pkt_len;   // Frame length in bytes
		logic [47:0]              mac_da;
		logic [47:0]              mac_sa;
		logic [15:0]              idle_cnt;  // Gap cycles between frames
		logic                     vlan_en;
		logic [31:0]              vlan_word;
	} pg_cfg_t;

	// Generator status back to the read mux
	typedef struct packed {
		logic        done;
		logic [31:0] tx_pkt_cnt;
	} pg_status_t;

	// Receive monitor counters
	typedef struct packed {
		logic [31:0] good_pkts;
		logic [31:0] err_pkts;
		logic [31:0] rx_bytes;
	} mon_counts_t;

endpackage

/* pg_frame_pkg.sv */
// Frame-side types for the MAC client beat stream and the fourth header word
package pg_frame_pkg;

	// One 32-bit MAC client beat
	typedef struct packed {
		logic        sop;
		logic        eop;
		logic [1:0]  mod;   // Unused bytes on the eop beat
		logic [31:0] data;
	} pkt_beat_t;

	// 802.1Q tag as sent in the fourth word
	typedef struct packed {
		logic [15:0] ether_type;
		logic [2:0]  pcp;
		logic        dei;
		logic [11:0] vid;
	} vlan_tag_t;

	// Sequence number and payload length word
	typedef struct packed {
		logic [15:0] seq;
		logic [15:0] pay_len;
	} len_seq_t;

	// Fourth header word, read either way
	typedef union packed {
		vlan_tag_t vlan;
		len_seq_t  len_seq;
	} tag_word_u;

endpackage

/* apb_regs.sv */
// APB register file holding the generator settings, control strobes and readback mux
`timescale 1ns/1ps
`include "pg_consts.svh"

module apb_regs import pg_regs_pkg::*; (
	input  logic        SYSCLK_IN,
	input  logic        PRESET_N_IN,
	input  apb_req_t    bus_req,
	output logic [31:0] prdata,
	output pg_cfg_t     cfg,
	output logic        start_pulse,
	output logic        stop_req,
	output logic        mon_clear,
	input  pg_status_t  status,
	input  mon_counts_t counts
);

	logic wr_en;
	logic rd_en;

	assign wr_en = bus_req.sel & bus_req.enable & bus_req.write; // Completes in the enable cycle
	assign rd_en = bus_req.sel & bus_req.enable & ~bus_req.write;

	// ----------------------------------------------------------
	// Write decode
	// ----------------------------------------------------------
	always_ff @(posedge SYSCLK_IN) begin
		if (!PRESET_N_IN) begin
			cfg.num_pkts  <= `PG_RST_NUM_PKTS;
			cfg.pkt_len   <= `PG_RST_PKT_LEN;
			cfg.mac_da    <= '0;
			cfg.mac_sa    <= '0;
			cfg.idle_cnt  <= `PG_RST_IDLE_CNT;
			cfg.vlan_en   <= 1'b0;
			cfg.vlan_word <= `PG_RST_VLAN_WORD;
			stop_req      <= 1'b0;
			start_pulse   <= 1'b0;
			mon_clear     <= 1'b0;
		end else begin
			start_pulse <= 1'b0; // Strobes last one cycle
			mon_clear   <= 1'b0;
			if (wr_en) begin
				case (bus_req.addr)
					`PG_ADDR_START:     start_pulse <= bus_req.wdata[0];
					`PG_ADDR_STOP:      stop_req <= bus_req.wdata[0];
					`PG_ADDR_NUMPKTS:   cfg.num_pkts <= bus_req.wdata;
					`PG_ADDR_PKTLEN: begin
						// Oversized lengths saturate
						if (bus_req.wdata > 32'(`PG_MAX_PKT_LEN))
							cfg.pkt_len <= `PG_MAX_PKT_LEN;
						else
							cfg.pkt_len <= bus_req.wdata[`PG_PKTLEN_W-1:0];
					end
					`PG_ADDR_MACSA0:    cfg.mac_sa[31:0] <= bus_req.wdata;
					`PG_ADDR_MACSA1:    cfg.mac_sa[47:32] <= bus_req.wdata[15:0];
					`PG_ADDR_MACDA0:    cfg.mac_da[31:0] <= bus_req.wdata;
					`PG_ADDR_MACDA1:    cfg.mac_da[47:32] <= bus_req.wdata[15:0];
					`PG_ADDR_IDLE_CNT:  cfg.idle_cnt <= bus_req.wdata[15:0];
					`PG_ADDR_MON_CTRL:  mon_clear <= bus_req.wdata[0];
					`PG_ADDR_VLAN_EN:   cfg.vlan_en <= bus_req.wdata[0];
					`PG_ADDR_VLAN_WORD: cfg.vlan_word <= bus_req.wdata;
					default: ;
				endcase
			end
		end
	end

	// ----------------------------------------------------------
	// Read mux, valid only in the enable phase
	// ----------------------------------------------------------
	always_comb begin
		prdata = '0;
		if (rd_en) begin
			case (bus_req.addr)
				`PG_ADDR_START:     prdata = {31'd0, start_pulse};
				`PG_ADDR_STOP:      prdata = {31'd0, stop_req};
				`PG_ADDR_DONE:      prdata = {31'd0, status.done};
				`PG_ADDR_NUMPKTS:   prdata = cfg.num_pkts;
				`PG_ADDR_PKTLEN:    prdata = {21'd0, cfg.pkt_len};
				`PG_ADDR_MACSA0:    prdata = cfg.mac_sa[31:0];
				`PG_ADDR_MACSA1:    prdata = {16'd0, cfg.mac_sa[47:32]};
				`PG_ADDR_MACDA0:    prdata = cfg.mac_da[31:0];
				`PG_ADDR_MACDA1:    prdata = {16'd0, cfg.mac_da[47:32]};
				`PG_ADDR_IDLE_CNT:  prdata = {16'd0, cfg.idle_cnt};
				`PG_ADDR_TXPKTCNT:  prdata = status.tx_pkt_cnt;
				`PG_ADDR_MON_CTRL:  prdata = {31'd0, mon_clear};
				`PG_ADDR_GOOD_PKTS: prdata = counts.good_pkts;
				`PG_ADDR_ERR_PKTS:  prdata = counts.err_pkts;
				`PG_ADDR_RX_BYTES:  prdata = counts.rx_bytes;
				`PG_ADDR_VLAN_EN:   prdata = {31'd0, cfg.vlan_en};
				`PG_ADDR_VLAN_WORD: prdata = cfg.vlan_word;
				default:            prdata = '0; // Unmapped
			endcase
		end
	end

endmodule

/* frame_gen.sv */
// Transmit frame generator FSM with gap timer and frame counter, driven by the register file
`timescale 1ns/1ps
`include "pg_consts.svh"

module frame_gen import pg_regs_pkg::*, pg_frame_pkg::*; (
	input  logic       SYSCLK_IN,
	input  logic       PRESET_N_IN,
	input  pg_cfg_t    cfg,
	input  logic       start_pulse,
	input  logic       stop_req,
	input  logic       tx_ready,
	output logic       tx_valid,
	output pkt_beat_t  tx_beat,
	output pg_status_t status
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_DA,
		S_DASA,
		S_SA,
		S_VLAN,
		S_LEN,
		S_PAY,
		S_LAST,
		S_GAP
	} gen_state_e;

	gen_state_e              state;
	logic [`PG_PKTLEN_W-1:0] eff_len;
	logic [11:0]             len_p3;
	logic [9:0]              beats;
	logic [9:0]              pay_words;
	logic [1:0]              eop_mod;
	logic [9:0]              pay_idx;   // Current payload word, from 1
	logic [15:0]             gap_cnt;
	logic [31:0]             pkt_cnt;
	logic                    done;
	logic                    has_beat;
	logic                    send;
	tag_word_u               tag_w;
	pkt_beat_t               beat_nxt;

	// ----------------------------------------------------------
	// Frame geometry
	// ----------------------------------------------------------
	assign eff_len   = (cfg.pkt_len < `PG_MIN_PKT_LEN) ? `PG_MIN_PKT_LEN : cfg.pkt_len;
	assign len_p3    = {1'b0, eff_len} + 12'd3;
	assign beats     = len_p3[11:2];                             // ceil(L/4)
	assign pay_words = beats - 10'd4 - {9'd0, cfg.vlan_en};      // Header takes 4 or 5 beats
	assign eop_mod   = 2'd0 - eff_len[1:0];

	// Fourth word is the VLAN tag or the sequence/length word
	always_comb begin
		if (state == S_VLAN) begin
			tag_w = cfg.vlan_word;
		end else begin
			tag_w.len_seq.seq     = pkt_cnt[15:0];
			tag_w.len_seq.pay_len = {5'd0, eff_len} - `PG_ETH_HDR_BYTES;
		end
	end

	// Beat offered by the current state
	always_comb begin
		beat_nxt = '0;
		has_beat = 1'b1;
		case (state)
			S_DA:   begin
				beat_nxt.sop  = 1'b1;
				beat_nxt.data = cfg.mac_da[47:16];
			end
			S_DASA: beat_nxt.data = {cfg.mac_da[15:0], cfg.mac_sa[47:32]};
			S_SA:   beat_nxt.data = cfg.mac_sa[31:0];
			S_VLAN,
			S_LEN:  beat_nxt.data = tag_w;
			S_PAY:  beat_nxt.data = {22'd0, pay_idx};
			S_LAST: begin
				beat_nxt.eop  = 1'b1;
				beat_nxt.mod  = eop_mod;
				beat_nxt.data = {22'd0, pay_idx};
			end
			default: has_beat = 1'b0; // Idle and gap
		endcase
	end

	assign send = has_beat & tx_ready;

	// ----------------------------------------------------------
	// Output registers
	// ----------------------------------------------------------
	always_ff @(posedge SYSCLK_IN) begin
		if (!PRESET_N_IN) begin
			tx_valid    <= 1'b0;
			tx_beat.sop <= 1'b0;
			tx_beat.eop <= 1'b0;
		end else begin
			tx_valid    <= send;
			tx_beat.sop <= send & beat_nxt.sop;
			tx_beat.eop <= send & beat_nxt.eop;
		end
	end

	always_ff @(posedge SYSCLK_IN) begin
		if (send) begin
			tx_beat.mod  <= beat_nxt.mod;
			tx_beat.data <= beat_nxt.data;
		end
	end

	// ----------------------------------------------------------
	// Sequencing FSM
	// ----------------------------------------------------------
	always_ff @(posedge SYSCLK_IN) begin
		if (!PRESET_N_IN) begin
			state   <= S_IDLE;
			pay_idx <= '0;
			gap_cnt <= '0;
			pkt_cnt <= '0;
			done    <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (start_pulse) begin
					state   <= S_DA;
					done    <= 1'b0;
					pkt_cnt <= '0;
				end
				S_DA:   if (tx_ready) state <= S_DASA;
				S_DASA: if (tx_ready) state <= S_SA;
				S_SA:   if (tx_ready) state <= cfg.vlan_en ? S_VLAN : S_LEN;
				S_VLAN: if (tx_ready) state <= S_LEN;
				S_LEN:  if (tx_ready) begin
					pay_idx <= 10'd1;
					state   <= (pay_words == 10'd1) ? S_LAST : S_PAY;
				end
				S_PAY:  if (tx_ready) begin
					pay_idx <= pay_idx + 10'd1;
					if (pay_idx == pay_words - 10'd1)
						state <= S_LAST;
				end
				S_LAST: if (tx_ready) begin
					pkt_cnt <= pkt_cnt + 32'd1; // Counted on the eop beat
					gap_cnt <= '0;
					state   <= S_GAP;
				end
				S_GAP: begin
					if (gap_cnt < cfg.idle_cnt) begin
						gap_cnt <= gap_cnt + 16'd1;
					end else if (stop_req ||
							(cfg.num_pkts != 32'd0 && pkt_cnt >= cfg.num_pkts)) begin
						state <= S_IDLE;
						done  <= 1'b1;
					end else begin
						state <= S_DA;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign status.done       = done;
	assign status.tx_pkt_cnt = pkt_cnt;

endmodule

/* rx_monitor.sv */
// Receive monitor counting good and errored frames and bytes, and driving rx_ready
`timescale 1ns/1ps

module rx_monitor import pg_regs_pkg::*, pg_frame_pkg::*; (
	input  logic        SYSCLK_IN,
	input  logic        PRESET_N_IN,
	input  pkt_beat_t   rx_beat,
	input  logic        rx_valid,
	input  logic        rx_err,
	input  logic        mon_clear,
	output logic        rx_ready,
	output mon_counts_t counts
);

	logic        in_frame;
	logic [31:0] beat_bytes;

	// Full word except on eop, where mod bytes are unused
	assign beat_bytes = rx_beat.eop ? (32'd4 - {30'd0, rx_beat.mod}) : 32'd4;

	// ----------------------------------------------------------
	// Counters
	// ----------------------------------------------------------
	always_ff @(posedge SYSCLK_IN) begin
		if (!PRESET_N_IN) begin
			counts <= '0;
		end else if (mon_clear) begin
			counts <= '0;
		end else if (rx_valid) begin
			counts.rx_bytes <= counts.rx_bytes + beat_bytes;
			if (rx_beat.eop) begin
				if (rx_err)
					counts.err_pkts <= counts.err_pkts + 32'd1;
				else
					counts.good_pkts <= counts.good_pkts + 32'd1;
			end
		end
	end

	// Ready window from sop to eop
	always_ff @(posedge SYSCLK_IN) begin
		if (!PRESET_N_IN) begin
			in_frame <= 1'b0;
		end else if (rx_valid) begin
			if (rx_beat.eop)
				in_frame <= 1'b0;
			else if (rx_beat.sop)
				in_frame <= 1'b1;
		end
	end

	assign rx_ready = in_frame | (rx_valid & rx_beat.sop); // High already in the sop cycle

endmodule

/* pg_top.sv */
// Top level of the frame generator and checker, wiring register file, generator and monitor
`timescale 1ns/1ps

module pg_top import pg_regs_pkg::*, pg_frame_pkg::*; (
	input  logic        SYSCLK_IN,
	input  logic        PRESET_N_IN,
	input  apb_req_t    bus_req,
	output logic [31:0] prdata,
	output logic        pready,
	input  logic        tx_ready,
	output logic        tx_valid,
	output pkt_beat_t   tx_beat,
	input  pkt_beat_t   rx_beat,
	input  logic        rx_valid,
	input  logic        rx_err,
	output logic        rx_ready
);

	pg_cfg_t     cfg;
	pg_status_t  status;
	mon_counts_t counts;
	logic        start_pulse;
	logic        stop_req;
	logic        mon_clear;

	assign pready = 1'b1; // No wait states

	apb_regs u_apb_regs (
		.SYSCLK_IN   (SYSCLK_IN),
		.PRESET_N_IN (PRESET_N_IN),
		.bus_req     (bus_req),
		.prdata      (prdata),
		.cfg         (cfg),
		.start_pulse (start_pulse),
		.stop_req    (stop_req),
		.mon_clear   (mon_clear),
		.status      (status),
		.counts      (counts)
	);

	frame_gen u_frame_gen (
		.SYSCLK_IN   (SYSCLK_IN),
		.PRESET_N_IN (PRESET_N_IN),
		.cfg         (cfg),
		.start_pulse (start_pulse),
		.stop_req    (stop_req),
		.tx_ready    (tx_ready),
		.tx_valid    (tx_valid),
		.tx_beat     (tx_beat),
		.status      (status)
	);

	rx_monitor u_rx_monitor (
		.SYSCLK_IN   (SYSCLK_IN),
		.PRESET_N_IN (PRESET_N_IN),
		.rx_beat     (rx_beat),
		.rx_valid    (rx_valid),
		.rx_err      (rx_err),
		.mon_clear   (mon_clear),
		.rx_ready    (rx_ready),
		.counts      (counts)
	);

endmodule

/* pg_asserts.sv */
// Concurrent checks on the transmit handshake of frame_gen, attached by bind
`timescale 1ns/1ps

module pg_asserts import pg_frame_pkg::*; (
	input logic      SYSCLK_IN,
	input logic      PRESET_N_IN,
	input logic      tx_ready,
	input logic      tx_valid,
	input pkt_beat_t tx_beat
);

	int fail_cnt = 0; // Summed into the testbench error count

	a_valid_after_reset: assert property (@(posedge SYSCLK_IN) !PRESET_N_IN |=> !tx_valid)
		else begin
			$error("tx_valid high in the cycle after reset");
			fail_cnt++;
		end

	// ----------------------------------------------------------
	// Back-pressure and framing
	// ----------------------------------------------------------
	a_no_beat_after_stall: assert property (@(posedge SYSCLK_IN) disable iff (!PRESET_N_IN)
		!tx_ready |=> !tx_valid)
		else begin
			$error("Beat sent after a cycle with tx_ready low");
			fail_cnt++;
		end

	a_sop_single: assert property (@(posedge SYSCLK_IN) disable iff (!PRESET_N_IN)
		tx_valid && tx_beat.sop |=> !tx_beat.sop)
		else begin
			$error("sop held for more than one cycle");
			fail_cnt++;
		end

	a_eop_single: assert property (@(posedge SYSCLK_IN) disable iff (!PRESET_N_IN)
		tx_valid && tx_beat.eop |=> !tx_beat.eop)
		else begin
			$error("eop held for more than one cycle");
			fail_cnt++;
		end

endmodule

bind frame_gen pg_asserts u_pg_asserts (
	.SYSCLK_IN   (SYSCLK_IN),
	.PRESET_N_IN (PRESET_N_IN),
	.tx_ready    (tx_ready),
	.tx_valid    (tx_valid),
	.tx_beat     (tx_beat)
);

/* tb_pg_top.sv */
// Testbench for pg_top driving APB setup, a transmit frame model and loopback into the monitor
`timescale 1ns/1ps
`include "pg_consts.svh"

module tb_pg_top import pg_regs_pkg::*, pg_frame_pkg::*; ();

	logic        SYSCLK_IN = 1'b0;
	logic        PRESET_N_IN;
	apb_req_t    bus_req;
	logic [31:0] prdata;
	logic        pready;
	logic        tx_ready = 1'b0;
	logic        tx_valid;
	pkt_beat_t   tx_beat;
	pkt_beat_t   rx_beat = '0;
	logic        rx_valid = 1'b0;
	logic        rx_err = 1'b0;
	logic        rx_ready;

	// Model view of the programmed settings
	int          t_len = 64;
	int          t_idle = 12;
	logic        t_vlan_en = 1'b0;
	logic [31:0] t_vlan_word = '0;
	logic [47:0] t_da = 48'h001b_21aa_bbcc;
	logic [47:0] t_sa = 48'h0200_5e10_2030;

	// ----------------------------------------------------------
	// Scoreboard state
	// ----------------------------------------------------------
	integer      seed = 32'hce2;
	logic [31:0] rnd;
	logic        rand_ready = 1'b0;
	int          errors = 0;      // Register checks
	int          mon_errors = 0;  // Beat and gap checks
	int          test_no = 0;
	int          failed_tests = 0;
	int          err_base = 0;
	int          wd_cycles = 0;
	int          wd_start = 0;
	int          wd_limit = 300;  // Covers reset
	int          frames_total = 0;
	int          frame_base = 0;
	int          beat_idx = 0;
	int          last_beats = 0;
	int          idle_run = 0;
	int          lb_total = 0;
	logic [31:0] err_frames = '0; // Frames looped back with rx_err
	logic        rx_open = 1'b0;  // Receive side between sop and eop
	int          good_total = 0;
	int          errp_total = 0;
	int          bytes_total = 0;
	int          good_base;
	int          errp_base;
	int          bytes_base;
	pkt_beat_t   exp_beat;
	logic [31:0] wv;

	logic [7:0]  rw_addr [10] = '{`PG_ADDR_STOP, `PG_ADDR_NUMPKTS, `PG_ADDR_VLAN_EN,
		`PG_ADDR_PKTLEN, `PG_ADDR_MACSA0, `PG_ADDR_MACSA1, `PG_ADDR_MACDA0,
		`PG_ADDR_MACDA1, `PG_ADDR_IDLE_CNT, `PG_ADDR_VLAN_WORD};
	logic [31:0] rw_mask [10] = '{32'h1, 32'hffff_ffff, 32'h1, 32'h7ff, 32'hffff_ffff,
		32'hffff, 32'hffff_ffff, 32'hffff, 32'hffff, 32'hffff_ffff};

	pg_top u_pg_top (
		.SYSCLK_IN   (SYSCLK_IN),
		.PRESET_N_IN (PRESET_N_IN),
		.bus_req     (bus_req),
		.prdata      (prdata),
		.pready      (pready),
		.tx_ready    (tx_ready),
		.tx_valid    (tx_valid),
		.tx_beat     (tx_beat),
		.rx_beat     (rx_beat),
		.rx_valid    (rx_valid),
		.rx_err      (rx_err),
		.rx_ready    (rx_ready)
	);

	always #4 SYSCLK_IN = ~SYSCLK_IN;

	// MAC back-pressure with about 3 in 4 cycles ready when randomized
	always @(posedge SYSCLK_IN) begin
		#1;
		if (rand_ready) begin
			rnd = $random(seed);
			tx_ready = (rnd[1:0] != 2'b00);
		end else begin
			tx_ready = 1'b1;
		end
	end

	// Loopback of the transmit beats into the receive side
	always @(posedge SYSCLK_IN) begin
		#1;
		rx_valid = tx_valid;
		rx_beat  = tx_valid ? tx_beat : '0;
		rx_err   = tx_valid & tx_beat.eop & err_frames[5'(lb_total - frame_base)];
		if (tx_valid && tx_beat.eop)
			lb_total++;
	end

	// ----------------------------------------------------------
	// Frame model
	// ----------------------------------------------------------
	function automatic pkt_beat_t model_beat(input int frame, input int idx);
		pkt_beat_t b;
		tag_word_u w;
		int        nb;
		int        hdr;
		b   = '0;
		nb  = (t_len + 3) / 4;
		hdr = t_vlan_en ? 5 : 4;
		w.len_seq.seq     = 16'(frame);
		w.len_seq.pay_len = 16'(t_len - 14);
		b.sop = (idx == 0);
		b.eop = (idx == nb - 1);
		if (b.eop)
			b.mod = 2'((4 - t_len % 4) % 4);
		if (idx == 0)
			b.data = t_da[47:16];
		else if (idx == 1)
			b.data = {t_da[15:0], t_sa[47:32]};
		else if (idx == 2)
			b.data = t_sa[31:0];
		else if (idx == 3 && t_vlan_en)
			b.data = t_vlan_word;
		else if (idx == hdr - 1)
			b.data = w;
		else
			b.data = 32'(idx - hdr + 1); // Payload counts from 1
		return b;
	endfunction

	always @(negedge SYSCLK_IN) begin
		if (PRESET_N_IN && tx_valid) begin
			exp_beat = model_beat(frames_total - frame_base, beat_idx);
			assert (tx_beat == exp_beat) else begin
				$display("CHECK FAILED at %0t: tx_beat expected %h, got %h",
					$time, exp_beat, tx_beat);
				mon_errors++;
			end
			if (tx_beat.sop && frames_total != frame_base) begin
				assert (idle_run >= t_idle) else begin
					$display("Gap before frame %0d lasted %0d cycles, below the idle count %0d",
						frames_total - frame_base, idle_run, t_idle);
					mon_errors++;
				end
			end
			idle_run = 0;
			if (tx_beat.eop) begin
				if (err_frames[5'(frames_total - frame_base)])
					errp_total++;
				else
					good_total++;
				bytes_total += t_len;
				frames_total++;
				last_beats = beat_idx + 1;
				beat_idx = 0;
			end else begin
				beat_idx++;
			end
		end else begin
			idle_run++;
		end
	end

	// Receive ready stays high from the sop beat through the eop beat
	always @(negedge SYSCLK_IN) begin
		if (PRESET_N_IN) begin
			assert (rx_ready == (rx_open | rx_valid)) else begin
				$display("CHECK FAILED at %0t: rx_ready expected %b, got %b",
					$time, rx_open | rx_valid, rx_ready);
				mon_errors++;
			end
			if (rx_valid && rx_beat.eop)
				rx_open = 1'b0;
			else if (rx_valid && rx_beat.sop)
				rx_open = 1'b1;
		end
	end

	// ----------------------------------------------------------
	// APB tasks and test helpers
	// ----------------------------------------------------------
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge SYSCLK_IN);
		#1;
		bus_req = '{sel: 1'b1, enable: 1'b0, write: 1'b1, addr: addr, wdata: data};
		@(posedge SYSCLK_IN);
		#1;
		bus_req.enable = 1'b1;
		@(posedge SYSCLK_IN);
		#1;
		bus_req = '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge SYSCLK_IN);
		#1;
		bus_req = '{sel: 1'b1, enable: 1'b0, write: 1'b0, addr: addr, wdata: 32'd0};
		@(posedge SYSCLK_IN);
		#1;
		bus_req.enable = 1'b1;
		@(negedge SYSCLK_IN);
		data = prdata;
		@(posedge SYSCLK_IN);
		#1;
		bus_req = '0;
	endtask

	function automatic int total_errors();
		return errors + mon_errors + u_pg_top.u_frame_gen.u_pg_asserts.fail_cnt;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic read_check(input string name, input logic [7:0] addr,
			input logic [31:0] exp);
		logic [31:0] val;
		apb_read(addr, val);
		check_value("pready", 32'(pready), 32'd1);
		check_value(name, val, exp);
	endtask

	task automatic configure(input int len, input int n, input int idle,
			input logic vlan_en, input logic [31:0] vlan_word);
		t_len       = len;
		t_idle      = idle;
		t_vlan_en   = vlan_en;
		t_vlan_word = vlan_word;
		apb_write(`PG_ADDR_NUMPKTS, 32'(n));
		apb_write(`PG_ADDR_PKTLEN, 32'(len));
		apb_write(`PG_ADDR_MACDA0, t_da[31:0]);
		apb_write(`PG_ADDR_MACDA1, {16'd0, t_da[47:32]});
		apb_write(`PG_ADDR_MACSA0, t_sa[31:0]);
		apb_write(`PG_ADDR_MACSA1, {16'd0, t_sa[47:32]});
		apb_write(`PG_ADDR_IDLE_CNT, 32'(idle));
		apb_write(`PG_ADDR_VLAN_EN, {31'd0, vlan_en});
		apb_write(`PG_ADDR_VLAN_WORD, vlan_word);
		apb_write(`PG_ADDR_STOP, 32'd0);
	endtask

	// Watchdog budget is four times the beats and gaps of the test
	task automatic begin_test(input int frames);
		test_no++;
		err_base   = total_errors();
		frame_base = frames_total;
		err_frames = '0;
		wd_start   = wd_cycles;
		wd_limit   = frames * ((t_len + 3) / 4 + t_idle + 8) * 4 + 400;
	endtask

	task automatic end_test(input string name);
		if (total_errors() == err_base) begin
			$display("Test %0d %s: ok", test_no, name);
		end else begin
			failed_tests++;
			$display("Test %0d %s: %0d errors", test_no, name, total_errors() - err_base);
		end
	endtask

	task automatic wait_done();
		logic [31:0] val;
		val = '0;
		while (val[0] !== 1'b1)
			apb_read(`PG_ADDR_DONE, val);
	endtask

	task automatic run_frames(input int frames);
		apb_write(`PG_ADDR_START, 32'd1);
		read_check("DONE after start", `PG_ADDR_DONE, 32'd0);
		wait_done();
		check_value("frames seen", 32'(frames_total - frame_base), 32'(frames));
		check_value("beats per frame", 32'(last_beats), 32'((t_len + 3) / 4));
		read_check("TXPKTCNT", `PG_ADDR_TXPKTCNT, 32'(frames));
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial begin
		bus_req     = '0;
		PRESET_N_IN = 1'b0;
		repeat (10) @(posedge SYSCLK_IN);
		#1;
		PRESET_N_IN = 1'b1;

		begin_test(0);
		for (int i = 0; i < 10; i++) begin
			wv = (32'h5a3c_96e1 ^ (32'(i) * 32'h0101_0101)) & rw_mask[i];
			apb_write(rw_addr[i], wv);
			read_check($sformatf("register 0x%02h", rw_addr[i]), rw_addr[i], wv);
		end
		read_check("unmapped 0xfc", 8'hfc, 32'd0);
		end_test("register readback");

		configure(61, 3, 8, 1'b0, 32'd0);
		begin_test(3);
		run_frames(3);
		end_test("three frames of 61 bytes");

		configure(70, 2, 6, 1'b1, 32'h8100_a07b);
		begin_test(2);
		run_frames(2);
		end_test("VLAN tagged frames");

		configure(45, 4, 5, 1'b0, 32'd0);
		begin_test(4);
		rand_ready = 1'b1;
		run_frames(4);
		rand_ready = 1'b0;
		end_test("random tx_ready");

		configure(40, 0, 3, 1'b0, 32'd0);
		begin_test(6);
		apb_write(`PG_ADDR_START, 32'd1);
		wait (frames_total - frame_base >= 3);
		apb_write(`PG_ADDR_STOP, 32'd1);
		wait_done();
		check_value("beat index after stop", 32'(beat_idx), 32'd0); // Frame boundary
		read_check("TXPKTCNT", `PG_ADDR_TXPKTCNT, 32'(frames_total - frame_base));
		apb_write(`PG_ADDR_STOP, 32'd0);
		end_test("endless run with stop");

		configure(50, 4, 4, 1'b0, 32'd0);
		begin_test(4);
		err_frames = 32'b1010;
		good_base  = good_total;
		errp_base  = errp_total;
		bytes_base = bytes_total;
		apb_write(`PG_ADDR_MON_CTRL, 32'd1);
		run_frames(4);
		read_check("GOOD_PKTS", `PG_ADDR_GOOD_PKTS, 32'(good_total - good_base));
		read_check("ERR_PKTS", `PG_ADDR_ERR_PKTS, 32'(errp_total - errp_base));
		read_check("RX_BYTES", `PG_ADDR_RX_BYTES, 32'(bytes_total - bytes_base));
		apb_write(`PG_ADDR_MON_CTRL, 32'd1);
		read_check("GOOD_PKTS after clear", `PG_ADDR_GOOD_PKTS, 32'd0);
		read_check("ERR_PKTS after clear", `PG_ADDR_ERR_PKTS, 32'd0);
		read_check("RX_BYTES after clear", `PG_ADDR_RX_BYTES, 32'd0);
		end_test("loopback counters");

		$display("Summary: %0d tests, %0d failed, %0d check errors",
			test_no, failed_tests, total_errors());
		if (total_errors() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		while (wd_cycles - wd_start <= wd_limit) begin
			@(posedge SYSCLK_IN);
			wd_cycles++;
		end
		$display("Timeout: test %0d ran past its limit of %0d cycles", test_no, wd_limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+.
pg_regs_pkg.sv
pg_frame_pkg.sv
apb_regs.sv
frame_gen.sv
rx_monitor.sv
pg_top.sv
pg_asserts.sv
tb_pg_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pg_top testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module tb_pg_top -o sim_pg

./obj_dir/sim_pg +verilator+error+limit+100 | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi
echo "Simulation passed"
